/* vic20_loader.f */
hw/loader_pkg.sv
hw/prg_loader.sv
hw/cart_loader.sv
hw/rom_loader.sv
hw/cfg_bus_arbiter.sv
hw/vic20_loader_top.sv
test/loader_checker.sv
test/tb_vic20_loader.sv

/* test/tb_vic20_loader.sv */
`default_nettype none

module tb_vic20_loader;
	import loader_pkg::*;

	// One file of the stimulus table
	typedef struct packed {
		logic  [7:0] kind;
		logic  [7:0] ext_char;
		logic [15:0] header;
		logic [15:0] first_ofs;
		logic [15:0] count;
		logic  [4:0] opts;
		logic  [4:0] exp_blk;
		logic        reset_before;
	} file_entry_t;

	logic        clk_sys;
	logic        reset;
	dl_port_t    dl;
	mem_opts_t   opts;
	cfg_wr_t     cfg_wr;
	logic        cfg_we;
	blk_mask_t   ram_ext;
	blk_mask_t   ram_ro;
	logic        check_now;
	logic  [7:0] test_id;
	blk_mask_t   exp_blk;
	int          pass_cnt;
	int          fail_cnt;
	int          cycle_cnt;
	int          cycle_limit;
	int          first_rnd;
	file_entry_t files [8];

	vic20_loader_top vic20_loader_top_inst (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.dl_i      (dl),
		.opts_i    (opts),
		.cfg_wr_o  (cfg_wr),
		.cfg_we_o  (cfg_we),
		.ram_ext_o (ram_ext),
		.ram_ro_o  (ram_ro)
	);

	loader_checker loader_checker_inst (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.dl_i       (dl),
		.opts_i     (opts),
		.cfg_wr_i   (cfg_wr),
		.cfg_we_i   (cfg_we),
		.ram_ext_i  (ram_ext),
		.ram_ro_i   (ram_ro),
		.check_i    (check_now),
		.test_id_i  (test_id),
		.exp_blk_i  (exp_blk),
		.pass_cnt_o (pass_cnt),
		.fail_cnt_o (fail_cnt)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt > cycle_limit) begin
			$display("Timeout, the run went past its limit of %0d cycles", cycle_limit);
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic apply_reset();
		reset <= 1'b1;
		repeat (16) @(posedge clk_sys);
		reset <= 1'b0;
	endtask

	task automatic request_check(input logic [7:0] id, input blk_mask_t blk);
		check_now <= 1'b1;
		test_id   <= id;
		exp_blk   <= blk;
		@(posedge clk_sys);
		check_now <= 1'b0;
	endtask

	//////////////////// Byte-stream driver

	task automatic send_file(input file_entry_t f);
		logic [24:0] ofs;
		logic [31:0] rnd;
		int          n;
		opts        <= f.opts;
		dl.index    <= f.kind;
		dl.ext_char <= f.ext_char;
		dl.download <= 1'b1;
		for (n = 0; n < f.count; n++) begin
			ofs = f.first_ofs + n;
			rnd = $urandom;
			repeat (3) @(posedge clk_sys);
			dl.wr   <= 1'b1;
			dl.addr <= ofs;
			case (ofs)
				25'd0: dl.data <= f.header[7:0];
				25'd1: dl.data <= f.header[15:8];
				default: dl.data <= rnd[7:0];
			endcase
			@(posedge clk_sys);
			dl.wr <= 1'b0;
		end
		repeat (3) @(posedge clk_sys);
		dl.download <= 1'b0;
		// Room for the pointer writes and the mask registers
		repeat (40) @(posedge clk_sys);
	endtask

	initial begin
		int i;
		first_rnd = $urandom(32'h0cabdfd7);
		reset     = 1'b1;
		dl        = '0;
		opts      = '0;
		check_now = 1'b0;
		test_id   = '0;
		exp_blk   = '0;
		cycle_cnt = 0;
		// kind, ext, header, first offset, bytes, opts, final blocks, reset first
		files[0] = '{FILE_KIND_PRG, "0", 16'h1201, 16'h0000, 16'd34, 5'h00, 5'h00, 1'b0};
		files[1] = '{FILE_KIND_PRG, "0", 16'h9FF0, 16'h0000, 16'd26, 5'h00, 5'h00, 1'b0};
		files[2] = '{FILE_KIND_ROM, "M", 16'h0000, 16'h3FF8, 16'd16, 5'h00, 5'h00, 1'b0};
		files[3] = '{FILE_KIND_ROM, "M", 16'h0000, 16'h7FF8, 16'd16, 5'h00, 5'h00, 1'b0};
		files[4] = '{FILE_KIND_CRT, "T", 16'hA000, 16'h0000, 16'd34, 5'h18, 5'h10, 1'b0};
		files[5] = '{FILE_KIND_CT,  "6", 16'h0000, 16'h0000, 16'd32, 5'h0F, 5'h18, 1'b0};
		files[6] = '{FILE_KIND_CT,  "B", 16'h0000, 16'h0000, 16'd32, 5'h04, 5'h10, 1'b1};
		files[7] = '{FILE_KIND_CRT, "T", 16'hBFF0, 16'h0000, 16'd34, 5'h0C, 5'h10, 1'b0};
		cycle_limit = 0;
		for (i = 0; i < $size(files); i++) begin
			cycle_limit = cycle_limit + 4 * files[i].count + 60;
		end
		cycle_limit = 2 * cycle_limit;

		apply_reset();
		// Quiet bus and option-only masks straight out of reset
		repeat (40) @(posedge clk_sys);
		request_check(8'd0, 5'b00000);
		for (i = 0; i < $size(files); i++) begin
			if (files[i].reset_before) begin
				apply_reset();
			end
			send_file(files[i]);
			request_check(i + 1, files[i].exp_blk);
		end
		@(posedge clk_sys);
		$display("Tests passed %0d, failed %0d", pass_cnt, fail_cnt);
		if ((fail_cnt == 0) && (pass_cnt == $size(files) + 1)) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* test/loader_checker.sv */
`default_nettype none

module loader_checker (
	input  wire                         clk_sys,
	input  wire                         reset,
	input  wire  loader_pkg::dl_port_t  dl_i,
	input  wire  loader_pkg::mem_opts_t opts_i,
	input  wire  loader_pkg::cfg_wr_t   cfg_wr_i,
	input  wire                         cfg_we_i,
	input  wire  loader_pkg::blk_mask_t ram_ext_i,
	input  wire  loader_pkg::blk_mask_t ram_ro_i,
	input  wire                         check_i,
	input  wire  [7:0]                  test_id_i,
	input  wire  loader_pkg::blk_mask_t exp_blk_i,
	output int                          pass_cnt_o,
	output int                          fail_cnt_o
);
	import loader_pkg::*;

	cfg_wr_t     exp_q [$];
	cfg_wr_t     exp_wr;
	logic [15:0] run_addr;
	logic        dl_prev;
	blk_mask_t   exp_ext;
	blk_mask_t   exp_ro;
	int          errs;

	initial begin
		pass_cnt_o = 0;
		fail_cnt_o = 0;
		errs       = 0;
		dl_prev    = 1'b0;
	end

	task automatic expect_write(input logic [15:0] addr, input logic [7:0] data);
		cfg_wr_t wr;
		wr.addr = addr;
		wr.data = data;
		exp_q.push_back(wr);
	endtask

	// BASIC start, variable and end pointers in write order
	function automatic logic [15:0] basic_ptr_addr(input int idx);
		case (idx)
			0: basic_ptr_addr = 16'h002D;
			1: basic_ptr_addr = 16'h002E;
			2: basic_ptr_addr = 16'h002F;
			3: basic_ptr_addr = 16'h0030;
			4: basic_ptr_addr = 16'h0031;
			5: basic_ptr_addr = 16'h0032;
			6: basic_ptr_addr = 16'h00AE;
			default: basic_ptr_addr = 16'h00AF;
		endcase
	endfunction

	// Bytes at or above the limit are dropped and the address stops there
	task automatic store_byte(input logic [15:0] limit);
		if (run_addr < limit) begin
			expect_write(run_addr, dl_i.data);
			run_addr = run_addr + 16'd1;
		end
	endtask

	//////////////////// Expected writes per file kind

	task automatic model_byte();
		if ((dl_i.index == FILE_KIND_PRG) || (dl_i.index == FILE_KIND_CRT)) begin
			if (dl_i.addr == 25'd0) begin
				run_addr[7:0] = dl_i.data;
			end else if (dl_i.addr == 25'd1) begin
				run_addr[15:8] = dl_i.data;
			end else begin
				store_byte((dl_i.index == FILE_KIND_PRG) ? 16'hA000 : 16'hC000);
			end
		end else if (dl_i.index == FILE_KIND_CT) begin
			store_byte(16'hC000);
		end else if ((dl_i.index == FILE_KIND_ROM) && (dl_i.addr >= 25'h4000) &&
			(dl_i.addr < 25'h8000)) begin
			expect_write(dl_i.addr[15:0] + 16'h8000, dl_i.data);
		end
	endtask

	task automatic compare_write();
		if (exp_q.size() == 0) begin
			$display("Extra write of %h to %h while no write was due", cfg_wr_i.data,
				cfg_wr_i.addr);
			errs++;
		end else begin
			exp_wr = exp_q.pop_front();
			if (cfg_wr_i.addr !== exp_wr.addr) begin
				$display("CHECK FAILED cfg_wr_o.addr expected %h got %h", exp_wr.addr,
					cfg_wr_i.addr);
				errs++;
			end
			if (cfg_wr_i.data !== exp_wr.data) begin
				$display("CHECK FAILED cfg_wr_o.data expected %h got %h", exp_wr.data,
					cfg_wr_i.data);
				errs++;
			end
		end
	endtask

	task automatic close_test();
		int ext2;
		// 0, 8, 16 or 24 KB fill blocks upward from $2000
		ext2 = (1 << opts_i.ext2_sel) - 1;
		if (exp_q.size() != 0) begin
			$display("Test %0d: %0d expected writes never came", test_id_i, exp_q.size());
			exp_q.delete();
			errs++;
		end
		exp_ext = exp_blk_i | {opts_i.ext3, ext2[2:0], opts_i.ext1};
		exp_ro  = opts_i.cart_writable ? 5'b00000 : exp_blk_i;
		if (ram_ext_i !== exp_ext) begin
			$display("CHECK FAILED ram_ext_o expected %h got %h", exp_ext, ram_ext_i);
			errs++;
		end
		if (ram_ro_i !== exp_ro) begin
			$display("CHECK FAILED ram_ro_o expected %h got %h", exp_ro, ram_ro_i);
			errs++;
		end
		if (errs == 0) begin
			pass_cnt_o = pass_cnt_o + 1;
			$display("Test %0d passed", test_id_i);
		end else begin
			fail_cnt_o = fail_cnt_o + 1;
			$display("Test %0d failed with %0d errors", test_id_i, errs);
		end
		errs = 0;
	endtask

	//////////////////// Watcher

	always @(posedge clk_sys) begin
		if (reset) begin
			dl_prev = 1'b0;
		end else begin
			// Start page from the extension character
			if (dl_i.download && !dl_prev && (dl_i.index == FILE_KIND_CT)) begin
				if ((dl_i.ext_char >= "2") && (dl_i.ext_char <= "9")) begin
					run_addr = (dl_i.ext_char - "0") * 16'h1000;
				end else if ((dl_i.ext_char == "A") || (dl_i.ext_char == "B")) begin
					run_addr = (dl_i.ext_char - "7") * 16'h1000;
				end
			end
			if (dl_i.download && dl_i.wr) begin
				model_byte();
			end
			// End of a program file queues the BASIC pointers
			if (dl_prev && !dl_i.download && (dl_i.index == FILE_KIND_PRG)) begin
				for (int i = 0; i < 8; i++) begin
					expect_write(basic_ptr_addr(i),
						(i % 2 == 1) ? run_addr[15:8] : run_addr[7:0]);
				end
			end
			dl_prev = dl_i.download;
			if (cfg_we_i) begin
				compare_write();
			end
			if (check_i) begin
				close_test();
			end
		end
	end

endmodule

`default_nettype wire

/* hw/vic20_loader_top.sv */
`default_nettype none

module vic20_loader_top (
	input  wire                         clk_sys,
	input  wire                         reset,
	input  wire  loader_pkg::dl_port_t  dl_i,
	input  wire  loader_pkg::mem_opts_t opts_i,
	output loader_pkg::cfg_wr_t         cfg_wr_o,
	output logic                        cfg_we_o,
	output loader_pkg::blk_mask_t       ram_ext_o,
	output loader_pkg::blk_mask_t       ram_ro_o
);
	import loader_pkg::*;

	// Requester 0 has the highest priority
	cfg_req_t           req [NUM_REQ];
	logic [NUM_REQ-1:0] grant;

	prg_loader prg_loader_inst (
		.clk_sys (clk_sys),
		.reset   (reset),
		.dl_i    (dl_i),
		.grant_i (grant[0]),
		.req_o   (req[0])
	);

	cart_loader cart_loader_inst (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.dl_i      (dl_i),
		.opts_i    (opts_i),
		.grant_i   (grant[1]),
		.req_o     (req[1]),
		.ram_ext_o (ram_ext_o),
		.ram_ro_o  (ram_ro_o)
	);

	rom_loader rom_loader_inst (
		.clk_sys (clk_sys),
		.reset   (reset),
		.dl_i    (dl_i),
		.grant_i (grant[2]),
		.req_o   (req[2])
	);

	cfg_bus_arbiter cfg_bus_arbiter_inst (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.req_i    (req),
		.grant_o  (grant),
		.cfg_wr_o (cfg_wr_o),
		.cfg_we_o (cfg_we_o)
	);

endmodule

`default_nettype wire

/* hw/cfg_bus_arbiter.sv */
`default_nettype none

module cfg_bus_arbiter (
	input  wire                             clk_sys,
	input  wire                             reset,
	input  wire  loader_pkg::cfg_req_t      req_i [loader_pkg::NUM_REQ],
	output logic [loader_pkg::NUM_REQ-1:0]  grant_o,
	output loader_pkg::cfg_wr_t             cfg_wr_o,
	output logic                            cfg_we_o
);
	import loader_pkg::*;

	cfg_wr_t win_wr;
	logic    any_grant;

	//////////////////// Priority select

	// Lowest index wins, so scan from the top and let it overwrite
	always_comb begin
		grant_o = '0;
		win_wr  = '0;
		for (int i = NUM_REQ - 1; i >= 0; i--) begin
			if (req_i[i].valid) begin
				grant_o    = '0;
				grant_o[i] = 1'b1;
				win_wr     = req_i[i].wr;
			end
		end
	end

	assign any_grant = |grant_o;

	//////////////////// Bus output

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cfg_we_o <= 1'b0;
		end else begin
			cfg_we_o <= any_grant;
		end
	end

	// Address and data hold their last value between writes
	always_ff @(posedge clk_sys) begin
		if (any_grant) begin
			cfg_wr_o <= win_wr;
		end
	end

endmodule

`default_nettype wire

/* hw/rom_loader.sv */
`default_nettype none

module rom_loader (
	input  wire                        clk_sys,
	input  wire                        reset,
	input  wire  loader_pkg::dl_port_t dl_i,
	input  wire                        grant_i,
	output loader_pkg::cfg_req_t       req_o
);
	import loader_pkg::*;

	logic    req_valid;
	cfg_wr_t req_wr;
	logic    in_range;
	logic    data_hit;

	// Kernal image sits in the upper half of the file
	assign in_range = (dl_i.addr >= ROM_LO) && (dl_i.addr < ROM_HI);
	assign data_hit = dl_i.download && (dl_i.index == FILE_KIND_ROM) &&
		dl_i.wr && in_range;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			req_valid <= 1'b0;
		end else begin
			if (grant_i) begin
				req_valid <= 1'b0;
			end
			// A new byte replaces any write still waiting
			if (data_hit) begin
				req_valid <= 1'b1;
			end
		end
	end

	//////////////////// Payload

	always_ff @(posedge clk_sys) begin
		if (data_hit) begin
			req_wr.addr <= dl_i.addr[15:0] + ROM_OFFSET;
			req_wr.data <= dl_i.data;
		end
	end

	assign req_o.valid = req_valid;
	assign req_o.wr    = req_wr;

endmodule

`default_nettype wire

/* hw/cart_loader.sv */
`default_nettype none

module cart_loader (
	input  wire                         clk_sys,
	input  wire                         reset,
	input  wire  loader_pkg::dl_port_t  dl_i,
	input  wire  loader_pkg::mem_opts_t opts_i,
	input  wire                         grant_i,
	output loader_pkg::cfg_req_t        req_o,
	output loader_pkg::blk_mask_t       ram_ext_o,
	output loader_pkg::blk_mask_t       ram_ro_o
);
	import loader_pkg::*;

	logic        req_valid;
	cfg_wr_t     req_wr;
	logic [15:0] load_addr;
	logic        dl_prev;
	blk_mask_t   blk_mask;

	logic        is_crt;
	logic        is_ct;
	logic        cart_active;
	logic        dl_rise;
	logic        hdr_byte;
	logic        data_hit;
	logic        ext_ok;
	logic [15:0] ext_addr;
	blk_mask_t   blk_hit;
	logic  [2:0] ext2_bits;
	blk_mask_t   opt_mask;

	//////////////////// Download decode

	assign is_crt      = (dl_i.index == FILE_KIND_CRT);
	assign is_ct       = (dl_i.index == FILE_KIND_CT);
	assign cart_active = dl_i.download && (is_crt || is_ct);
	assign dl_rise     = !dl_prev && dl_i.download && is_ct;

	// Only the address-in-file kind carries a header
	assign hdr_byte = is_crt && (dl_i.addr < 25'd2);
	assign data_hit = cart_active && dl_i.wr && !hdr_byte && (load_addr < CART_TOP);

	// Start address from the last extension character
	always_comb begin
		ext_ok   = 1'b0;
		ext_addr = '0;
		if ((dl_i.ext_char >= "2") && (dl_i.ext_char <= "9")) begin
			ext_ok   = 1'b1;
			ext_addr = {dl_i.ext_char[3:0], 12'h000};
		end else if ((dl_i.ext_char >= "A") && (dl_i.ext_char <= "B")) begin
			ext_ok   = 1'b1;
			ext_addr = {dl_i.ext_char[3:0] + 4'd9, 12'h000};
		end
	end

	// 8 KB block of the current address, $8000 block has no bit
	always_comb begin
		blk_hit = '0;
		case (load_addr[15:13])
			3'd0: blk_hit[0] = 1'b1;
			3'd1: blk_hit[1] = 1'b1;
			3'd2: blk_hit[2] = 1'b1;
			3'd3: blk_hit[3] = 1'b1;
			3'd5: blk_hit[4] = 1'b1;
			default: blk_hit = '0;
		endcase
	end

	//////////////////// Control

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_prev   <= 1'b0;
			req_valid <= 1'b0;
			blk_mask  <= '0;
		end else begin
			dl_prev <= dl_i.download;
			if (grant_i) begin
				req_valid <= 1'b0;
			end
			if (data_hit) begin
				req_valid <= 1'b1;
				blk_mask  <= blk_mask | blk_hit;
			end
		end
	end

	// Address and payload
	always_ff @(posedge clk_sys) begin
		if (dl_rise && ext_ok) begin
			load_addr <= ext_addr;
		end else if (cart_active && dl_i.wr) begin
			if (is_crt && (dl_i.addr == 25'd0)) begin
				load_addr[7:0] <= dl_i.data;
			end else if (is_crt && (dl_i.addr == 25'd1)) begin
				load_addr[15:8] <= dl_i.data;
			end else if (data_hit) begin
				req_wr.addr <= load_addr;
				req_wr.data <= dl_i.data;
				load_addr   <= load_addr + 16'd1;
			end
		end
	end

	//////////////////// Expansion masks

	always_comb begin
		case (opts_i.ext2_sel)
			2'd0: ext2_bits = 3'b000;
			2'd1: ext2_bits = 3'b001;
			2'd2: ext2_bits = 3'b011;
			default: ext2_bits = 3'b111;
		endcase
		opt_mask = {opts_i.ext3, ext2_bits, opts_i.ext1};
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ram_ext_o <= '0;
			ram_ro_o  <= '0;
		end else begin
			ram_ext_o <= blk_mask | opt_mask;
			// Cartridge blocks are read only unless the menu allows writes
			ram_ro_o  <= opts_i.cart_writable ? '0 : blk_mask;
		end
	end

	assign req_o.valid = req_valid;
	assign req_o.wr    = req_wr;

endmodule

`default_nettype wire

/* hw/prg_loader.sv */
`default_nettype none

module prg_loader (
	input  wire                        clk_sys,
	input  wire                        reset,
	input  wire  loader_pkg::dl_port_t dl_i,
	input  wire                        grant_i,
	output loader_pkg::cfg_req_t       req_o
);
	import loader_pkg::*;

	logic        req_valid;
	cfg_wr_t     req_wr;
	logic [15:0] load_addr;
	logic        dl_prev;
	logic        seq_active;
	logic        ptr_pend;
	logic  [2:0] ptr_step;

	logic        is_prg;
	logic        prg_active;
	logic        dl_fall;
	logic        data_hit;
	logic        ptr_issue;

	//////////////////// Download decode

	assign is_prg     = (dl_i.index == FILE_KIND_PRG);
	assign prg_active = dl_i.download && is_prg;
	assign dl_fall    = dl_prev && !dl_i.download && is_prg;

	// First two bytes are the load address, the rest is data below $A000
	assign data_hit = prg_active && dl_i.wr && (dl_i.addr > 25'd1) &&
		(load_addr < PRG_TOP);

	// Next pointer write once the previous one has been taken
	assign ptr_issue = seq_active && !req_valid && !prg_active;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_prev <= 1'b0;
		end else begin
			dl_prev <= dl_i.download;
		end
	end

	//////////////////// Request control

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			req_valid  <= 1'b0;
			seq_active <= 1'b0;
			ptr_pend   <= 1'b0;
			ptr_step   <= '0;
		end else begin
			if (grant_i) begin
				req_valid <= 1'b0;
				if (ptr_pend) begin
					ptr_pend <= 1'b0;
					ptr_step <= ptr_step + 3'd1;
					// Last pointer written
					if (ptr_step == 3'd7) begin
						seq_active <= 1'b0;
					end
				end
			end

			if (prg_active) begin
				seq_active <= 1'b0;
				if (data_hit) begin
					req_valid <= 1'b1;
				end
			end else if (dl_fall) begin
				seq_active <= 1'b1;
				ptr_step   <= '0;
			end else if (ptr_issue) begin
				req_valid <= 1'b1;
				ptr_pend  <= 1'b1;
			end
		end
	end

	//////////////////// Address and payload

	always_ff @(posedge clk_sys) begin
		if (prg_active && dl_i.wr) begin
			if (dl_i.addr == 25'd0) begin
				load_addr[7:0] <= dl_i.data;
			end else if (dl_i.addr == 25'd1) begin
				load_addr[15:8] <= dl_i.data;
			end else if (data_hit) begin
				req_wr.addr <= load_addr;
				req_wr.data <= dl_i.data;
				load_addr   <= load_addr + 16'd1;
			end
		end else if (ptr_issue) begin
			// Pointers alternate low and high byte of the end address
			req_wr.addr <= PTR_ADDRS[ptr_step];
			req_wr.data <= ptr_step[0] ? load_addr[15:8] : load_addr[7:0];
		end
	end

	assign req_o.valid = req_valid;
	assign req_o.wr    = req_wr;

endmodule

`default_nettype wire

/* hw/loader_pkg.sv */
`default_nettype none

package loader_pkg;

	//////////////////// Host download port

	typedef struct packed {
		logic        download;
		logic  [7:0] index;
		logic        wr;
		logic [24:0] addr;
		logic  [7:0] data;
		logic  [7:0] ext_char;
	} dl_port_t;

	//////////////////// Configuration bus

	typedef struct packed {
		logic [15:0] addr;
		logic  [7:0] data;
	} cfg_wr_t;

	// Held by a loader until its grant bit pulses
	typedef struct packed {
		logic    valid;
		cfg_wr_t wr;
	} cfg_req_t;

	// Memory menu options
	typedef struct packed {
		logic       ext1;
		logic [1:0] ext2_sel;
		logic       ext3;
		logic       cart_writable;
	} mem_opts_t;

	// One bit per block: $0400, $2000, $4000, $6000, $A000
	typedef logic [4:0] blk_mask_t;

	//////////////////// File kinds

	localparam logic [7:0] FILE_KIND_PRG = 8'h01;
	localparam logic [7:0] FILE_KIND_CRT = 8'h41;
	localparam logic [7:0] FILE_KIND_CT  = 8'h81;
	localparam logic [7:0] FILE_KIND_ROM = 8'h06;

	// Address limits
	localparam logic [15:0] PRG_TOP    = 16'hA000;
	localparam logic [15:0] CART_TOP   = 16'hC000;
	localparam logic [15:0] ROM_LO     = 16'h4000;
	localparam logic [15:0] ROM_HI     = 16'h8000;
	localparam logic [15:0] ROM_OFFSET = 16'h8000;

	localparam int NUM_REQ = 3;

	// BASIC start, variable and end pointers, low byte first
	localparam logic [15:0] PTR_ADDRS [8] = '{
		16'h002D, 16'h002E, 16'h002F, 16'h0030,
		16'h0031, 16'h0032, 16'h00AE, 16'h00AF
	};

endpackage

`default_nettype wire
